//--- pipe_trace_top.f
+incdir+tb
verilog/cpu_isa_pkg.sv
verilog/trace_pkg.sv
verilog/stage_tracker.sv
verilog/trace_store.sv
verilog/retire_queue.sv
verilog/pipe_trace_top.sv
tb/pipe_trace_tb.sv

//--- Makefile
# Verilator build and run of the pipeline trace unit testbench
VERILATOR ?= verilator
TOP       ?= pipe_trace_tb
RTL_TOP   ?= pipe_trace_top
FILELIST  ?= pipe_trace_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/pipe_trace_ref.svh
// Reference model for the trace unit testbench, with instruction and expected record types
`ifndef PIPE_TRACE_REF_SVH
`define PIPE_TRACE_REF_SVH

    // One instruction as the CPU model fed it
    typedef struct packed {
        logic [XLEN-1:0] pc;        // Driven while in fetch
        opcode_t         opcode;    // Driven while in decode
        logic [XLEN-1:0] exec_val;
        logic [XLEN-1:0] mem_val;
        logic [XLEN-1:0] wb_val;
        int              stalls;    // Edges held in fetch or decode
    } instr_t;

    // One record as the consumer sees it
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [XLEN-1:0]    pc;
        opcode_t            opcode;
        logic [STALL_W-1:0] stall_cycles;
        logic [XLEN-1:0]    exec_val;
        logic [XLEN-1:0]    mem_val;
        logic [XLEN-1:0]    wb_val;
    } trace_rec_t;

    // Expected record from an instruction and its sequence number since reset
    function automatic trace_rec_t ref_record(input int seq, input instr_t ins);
        trace_rec_t rec;
        rec.id           = ID_W'(seq % STORE_DEPTH);   // IDs wrap through the store slots
        rec.pc           = ins.pc;
        rec.opcode       = ins.opcode;
        rec.stall_cycles = (ins.stalls >= (1 << STALL_W) - 1) ? '1 : STALL_W'(ins.stalls);
        rec.exec_val     = (ins.opcode == OP_HLT) ? '0 : ins.exec_val;  // Halt stops at decode
        rec.mem_val      = (ins.opcode == OP_HLT) ? '0 : ins.mem_val;
        rec.wb_val       = (ins.opcode == OP_HLT) ? '0 : ins.wb_val;
        return rec;
    endfunction

`endif

//--- tb/pipe_trace_tb.sv
// Testbench for the pipeline trace unit, acting as CPU and as credit-returning consumer
`default_nettype none

module pipe_trace_tb
    import cpu_isa_pkg::*;
    import trace_pkg::*;
();

`include "pipe_trace_ref.svh"

    localparam int DRIVE_DLY = 10;      // Inputs change this long after the rising edge
    localparam int WAIT_MAX  = 300;     // Cycle limit of every wait loop

    logic               clk, rst_n, stall, trace_credit;
    logic [XLEN-1:0]    fetch_pc, exec_result, mem_addr, wb_data;
    opcode_t            decode_opcode;
    logic               trace_valid, trace_overflow, halted;
    logic [ID_W-1:0]    trace_id;
    logic [XLEN-1:0]    trace_pc, trace_exec, trace_mem, trace_wb;
    opcode_t            trace_opcode;
    logic [STALL_W-1:0] trace_stall_cycles;

    instr_t      prog[$];                       // Instructions fetched since reset, by sequence
    trace_rec_t  exp_q[$];                      // Records still to arrive
    int          f_idx, d_idx, e_idx, m_idx, w_idx;    // CPU stage contents, -1 is a bubble
    logic [31:0] rng = 32'd5;
    int          stall_mode;                    // 0 none, 1 random, 2 held high
    bit          inject_hlt, model_halted, credit_en;
    int          recv_count, returned, hold_mark;
    int          err_count, tests_failed, test_err0;
    string       cur_test;

    pipe_trace_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // CPU model
    ////////////////////////////////////////////////////////////////////////////

    task automatic fetch_new();
        instr_t ins;
        rng = xorshift32(rng);
        ins.pc = {rng[31:2], 2'b00};                // Word aligned
        rng = xorshift32(rng);
        ins.opcode = inject_hlt ? OP_HLT : opcode_t'(4'(rng % 32'd5));
        rng = xorshift32(rng);
        ins.exec_val = rng;
        rng = xorshift32(rng);
        ins.mem_val = rng;
        rng = xorshift32(rng);
        ins.wb_val = rng;
        ins.stalls = 0;
        inject_hlt = 1'b0;
        prog.push_back(ins);
        f_idx = prog.size() - 1;
    endtask

    // Moves the stages on one edge with the reset and stall seen at that edge
    task automatic advance_model(input logic s_rst, input logic s_stall);
        if (!s_rst || model_halted) begin
            {f_idx, d_idx, e_idx, m_idx, w_idx} = {5{-32'sd1}};
        end
        if (!s_rst) begin
            prog.delete();
            exp_q.delete();
            model_halted = 1'b0;
            returned     = recv_count;      // Queue is back to full credit
        end else if (!model_halted) begin
            w_idx = m_idx;
            m_idx = e_idx;
            if (s_stall) begin
                e_idx = -1;                 // Bubble into execute
                if (f_idx >= 0) prog[f_idx].stalls += 1;
                if (d_idx >= 0) prog[d_idx].stalls += 1;
            end else begin
                e_idx = d_idx;
                d_idx = f_idx;
                fetch_new();
            end
            if (w_idx >= 0) begin
                exp_q.push_back(ref_record(w_idx, prog[w_idx]));
                model_halted = (prog[w_idx].opcode == OP_HLT);
            end
        end
    endtask

    task automatic drive_inputs();
        rng = xorshift32(rng);
        case (stall_mode)
            0:       stall = 1'b0;
            1:       stall = (rng[2:0] < 3'd3);     // About three in eight
            default: stall = 1'b1;
        endcase
        fetch_pc      = (f_idx >= 0) ? prog[f_idx].pc : '0;
        decode_opcode = (d_idx >= 0) ? prog[d_idx].opcode : OP_NOP;
        exec_result   = (e_idx >= 0) ? prog[e_idx].exec_val : '0;
        mem_addr      = (m_idx >= 0) ? prog[m_idx].mem_val : '0;
        wb_data       = (w_idx >= 0) ? prog[w_idx].wb_val : '0;
        trace_credit  = credit_en && (recv_count > returned);  // One credit back per record
        if (trace_credit) returned++;
    endtask

    task automatic step();
        logic s_rst, s_stall;
        s_rst   = rst_n;
        s_stall = stall;
        @(posedge clk);
        #DRIVE_DLY;
        advance_model(s_rst, s_stall);
        drive_inputs();
    endtask

    task automatic run(input int cycles);
        repeat (cycles) step();
    endtask

    task automatic apply_reset(input int cycles);
        rst_n = 1'b0;
        run(cycles);
        rst_n = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Waits, checks and reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic timeout_fail(input string what);
        $display("timeout in test %s while waiting for %s", cur_test, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Holds the CPU until every expected record and credit has come back
    task automatic drain();
        int n;
        n = 0;
        stall_mode = 2;
        while ((exp_q.size() != 0 || recv_count != returned) && n < WAIT_MAX) begin
            step();
            n++;
        end
        if (exp_q.size() != 0 || recv_count != returned) timeout_fail("records to drain");
        step();     // Last credit lands in the queue
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted && n < WAIT_MAX) begin
            step();
            n++;
        end
        if (!halted) timeout_fail("halted");
    endtask

    task automatic mismatch_line(input string field, input logic [XLEN-1:0] e,
                                 input logic [XLEN-1:0] a);
        $display("mismatch %s %s expected %h actual %h", cur_test, field, e, a);
        err_count++;
    endtask

    task automatic compare_record(input trace_rec_t e, input trace_rec_t a);
        if (e.id != a.id) mismatch_line("id", XLEN'(e.id), XLEN'(a.id));
        if (e.pc != a.pc) mismatch_line("pc", e.pc, a.pc);
        if (e.opcode != a.opcode) mismatch_line("opcode", XLEN'(e.opcode), XLEN'(a.opcode));
        if (e.stall_cycles != a.stall_cycles)
            mismatch_line("stall_cycles", XLEN'(e.stall_cycles), XLEN'(a.stall_cycles));
        if (e.exec_val != a.exec_val) mismatch_line("exec", e.exec_val, a.exec_val);
        if (e.mem_val != a.mem_val) mismatch_line("mem", e.mem_val, a.mem_val);
        if (e.wb_val != a.wb_val) mismatch_line("wb", e.wb_val, a.wb_val);
    endtask

    task automatic compare_flag(input string what, input logic e, input logic a);
        if (e !== a) begin
            $display("mismatch %s %s expected %0b actual %0b", cur_test, what, e, a);
            err_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_err0) begin
            $display("test %s passed", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, err_count - test_err0);
            tests_failed++;
        end
    endtask

    // Consumer side, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin : compare_proc
        trace_rec_t got;
        if (rst_n && trace_valid) begin
            got.id           = trace_id;
            got.pc           = trace_pc;
            got.opcode       = trace_opcode;
            got.stall_cycles = trace_stall_cycles;
            got.exec_val     = trace_exec;
            got.mem_val      = trace_mem;
            got.wb_val       = trace_wb;
            if (exp_q.size() == 0) begin
                $display("unexpected record with id %0d in test %s", trace_id, cur_test);
                err_count++;
            end else begin
                compare_record(exp_q.pop_front(), got);
            end
            recv_count++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        {stall, trace_credit, inject_hlt, model_halted} = '0;
        {fetch_pc, exec_result, mem_addr, wb_data} = '0;
        decode_opcode = OP_NOP;
        {f_idx, d_idx, e_idx, m_idx, w_idx} = {5{-32'sd1}};
        {stall_mode, recv_count, returned, hold_mark, err_count, tests_failed} = '0;
        credit_en = 1'b1;
        cur_test  = "init";
        apply_reset(8);

        begin_test("straight_line");
        stall_mode = 0;
        run(30);
        drain();
        end_test();

        begin_test("random_stalls");
        stall_mode = 1;
        run(40);
        stall_mode = 2;
        run(20);                    // Long hold drives the counters into saturation
        stall_mode = 1;
        run(30);
        drain();
        end_test();

        begin_test("credit_backpressure");
        credit_en = 1'b0;
        hold_mark = recv_count;
        stall_mode = 0;
        run(6);                     // Fewer records than credits plus FIFO depth
        stall_mode = 2;
        run(10);
        if (recv_count - hold_mark > TRACE_CREDITS) begin
            $display("%0d records arrived without a returned credit in test %s",
                     recv_count - hold_mark, cur_test);
            err_count++;
        end
        compare_flag("trace_overflow", 1'b0, trace_overflow);
        credit_en = 1'b1;
        drain();
        end_test();

        begin_test("overflow");
        credit_en = 1'b0;
        hold_mark = recv_count;
        stall_mode = 0;
        run(20);
        stall_mode = 2;
        run(8);
        // Only the earliest records fit in the credits and the FIFO
        while (exp_q.size() > QUEUE_DEPTH + TRACE_CREDITS - (recv_count - hold_mark))
            void'(exp_q.pop_back());
        compare_flag("trace_overflow", 1'b1, trace_overflow);
        credit_en = 1'b1;
        drain();
        end_test();

        begin_test("halt");
        stall_mode = 1;
        inject_hlt = 1'b1;
        wait_halted();
        stall_mode = 0;
        run(20);                    // Any record now is flagged by the consumer
        compare_flag("halted", 1'b1, halted);
        if (exp_q.size() != 0) begin
            $display("halt record never arrived in test %s", cur_test);
            err_count++;
        end
        end_test();

        begin_test("reset");
        apply_reset(8);
        compare_flag("trace_valid", 1'b0, trace_valid);
        compare_flag("trace_overflow", 1'b0, trace_overflow);
        compare_flag("halted", 1'b0, halted);
        stall_mode = 0;
        run(20);                    // Expected IDs restart at zero
        drain();
        end_test();

        $display("tests run 6, tests failed %0d, errors %0d", tests_failed, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/pipe_trace_top.sv
// Pipeline trace unit top joining the stage tracker, trace store and retire queue
`default_nettype none

module pipe_trace_top
    import cpu_isa_pkg::*;
    import trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,               // CPU stall
    input  logic [XLEN-1:0]    fetch_pc,
    input  opcode_t            decode_opcode,
    input  logic [XLEN-1:0]    exec_result,
    input  logic [XLEN-1:0]    mem_addr,
    input  logic [XLEN-1:0]    wb_data,
    input  logic               trace_credit,        // Credit return from consumer
    output logic               trace_valid,
    output logic [ID_W-1:0]    trace_id,
    output logic [XLEN-1:0]    trace_pc,
    output opcode_t            trace_opcode,
    output logic [STALL_W-1:0] trace_stall_cycles,
    output logic [XLEN-1:0]    trace_exec,
    output logic [XLEN-1:0]    trace_mem,
    output logic [XLEN-1:0]    trace_wb,
    output logic               trace_overflow,
    output logic               halted
);

    // Tracker to store
    logic            v_fetch, v_decode, v_exec, v_mem, v_wb;
    logic [ID_W-1:0] id_fetch, id_decode, id_exec, id_mem, id_wb;
    logic            in_stall;
    opcode_t         wb_opcode;     // Store back to tracker

    // Store to queue
    logic               rec_push;
    logic [ID_W-1:0]    rec_id;
    logic [XLEN-1:0]    rec_pc;
    opcode_t            rec_opcode;
    logic [STALL_W-1:0] rec_stall_cycles;
    logic [XLEN-1:0]    rec_exec, rec_mem, rec_wb;

    stage_tracker tracker_i (
        .clk, .rst_n, .stall, .wb_opcode,
        .v_fetch, .v_decode, .v_exec, .v_mem, .v_wb,
        .id_fetch, .id_decode, .id_exec, .id_mem, .id_wb,
        .in_stall, .halted
    );

    trace_store store_i (
        .clk, .rst_n,
        .v_fetch, .v_decode, .v_exec, .v_mem, .v_wb,
        .id_fetch, .id_decode, .id_exec, .id_mem, .id_wb,
        .in_stall, .fetch_pc, .decode_opcode, .exec_result, .mem_addr, .wb_data,
        .wb_opcode, .rec_push, .rec_id, .rec_pc, .rec_opcode, .rec_stall_cycles,
        .rec_exec, .rec_mem, .rec_wb
    );

    retire_queue queue_i (
        .clk, .rst_n,
        .rec_push, .rec_id, .rec_pc, .rec_opcode, .rec_stall_cycles,
        .rec_exec, .rec_mem, .rec_wb, .trace_credit,
        .trace_valid, .trace_id, .trace_pc, .trace_opcode, .trace_stall_cycles,
        .trace_exec, .trace_mem, .trace_wb, .trace_overflow
    );

endmodule

`default_nettype wire

//--- verilog/retire_queue.sv
// Retire queue that buffers trace records and releases them against consumer credits
`default_nettype none

module retire_queue
    import cpu_isa_pkg::*;
    import trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rec_push,
    input  logic [ID_W-1:0]    rec_id,
    input  logic [XLEN-1:0]    rec_pc,
    input  opcode_t            rec_opcode,
    input  logic [STALL_W-1:0] rec_stall_cycles,
    input  logic [XLEN-1:0]    rec_exec,
    input  logic [XLEN-1:0]    rec_mem,
    input  logic [XLEN-1:0]    rec_wb,
    input  logic               trace_credit,    // One credit back per pulse
    output logic               trace_valid,
    output logic [ID_W-1:0]    trace_id,
    output logic [XLEN-1:0]    trace_pc,
    output opcode_t            trace_opcode,
    output logic [STALL_W-1:0] trace_stall_cycles,
    output logic [XLEN-1:0]    trace_exec,
    output logic [XLEN-1:0]    trace_mem,
    output logic [XLEN-1:0]    trace_wb,
    output logic               trace_overflow   // Sticky until reset
);

    logic [REC_W-1:0]    fifo_mem [QUEUE_DEPTH];
    logic [REC_W-1:0]    head;
    logic [OPC_W-1:0]    head_opc;
    logic [QPTR_W-1:0]   wr_ptr, rd_ptr;
    logic [QCNT_W-1:0]   count;
    logic [CREDIT_W-1:0] credits;
    logic                pop;       // Record leaves this cycle
    logic                accept;    // Pushed record is kept

    assign pop         = (count != '0) && (credits != '0);
    assign accept      = rec_push && ((count != QCNT_W'(QUEUE_DEPTH)) || pop);
    assign trace_valid = pop;

    // Head of FIFO drives the stream directly
    assign head = fifo_mem[rd_ptr];
    assign {trace_id, trace_pc, head_opc, trace_stall_cycles, trace_exec, trace_mem, trace_wb} = head;
    assign trace_opcode = opcode_t'(head_opc);

    always_ff @(posedge clk) begin
        if (accept)
            fifo_mem[wr_ptr] <= {rec_id, rec_pc, rec_opcode, rec_stall_cycles,
                                 rec_exec, rec_mem, rec_wb};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            credits        <= CREDIT_W'(TRACE_CREDITS);
            trace_overflow <= 1'b0;
        end else begin
            if (accept)
                wr_ptr <= wr_ptr + 1'b1;    // Depth is a power of two, pointers wrap
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count   <= count + QCNT_W'(accept) - QCNT_W'(pop);
            credits <= credits - CREDIT_W'(pop) + CREDIT_W'(trace_credit);
            if (rec_push && !accept)
                trace_overflow <= 1'b1;     // Record dropped, FIFO was full
        end
    end

    // Consumer returns no more credits than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CREDIT_W'(TRACE_CREDITS));

    // Spending the last credit stops the stream until one comes back
    a_no_send_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
        (trace_valid && (credits == CREDIT_W'(1)) && !trace_credit) |=> !trace_valid);

endmodule

`default_nettype wire

//--- verilog/trace_store.sv
// Trace store holding stage fields per sequence ID and assembling the retire record
`default_nettype none

module trace_store
    import cpu_isa_pkg::*;
    import trace_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               v_fetch,
    input  logic               v_decode,
    input  logic               v_exec,
    input  logic               v_mem,
    input  logic               v_wb,
    input  logic [ID_W-1:0]    id_fetch,
    input  logic [ID_W-1:0]    id_decode,
    input  logic [ID_W-1:0]    id_exec,
    input  logic [ID_W-1:0]    id_mem,
    input  logic [ID_W-1:0]    id_wb,
    input  logic               in_stall,
    input  logic [XLEN-1:0]    fetch_pc,
    input  opcode_t            decode_opcode,
    input  logic [XLEN-1:0]    exec_result,
    input  logic [XLEN-1:0]    mem_addr,
    input  logic [XLEN-1:0]    wb_data,
    output opcode_t            wb_opcode,       // To the tracker for halt detection
    output logic               rec_push,
    output logic [ID_W-1:0]    rec_id,
    output logic [XLEN-1:0]    rec_pc,
    output opcode_t            rec_opcode,
    output logic [STALL_W-1:0] rec_stall_cycles,
    output logic [XLEN-1:0]    rec_exec,
    output logic [XLEN-1:0]    rec_mem,
    output logic [XLEN-1:0]    rec_wb
);

    logic [XLEN-1:0]    pc_mem    [STORE_DEPTH];    // Fetch PC per ID
    opcode_t            opc_mem   [STORE_DEPTH];    // Decoded opcode per ID
    logic [STALL_W-1:0] stall_mem [STORE_DEPTH];    // Fetch plus decode stall cycles
    logic [XLEN-1:0]    exec_mem  [STORE_DEPTH];    // Execute result per ID
    logic [XLEN-1:0]    addr_mem  [STORE_DEPTH];    // Memory address per ID
    logic               wb_is_hlt;

    function automatic logic [STALL_W-1:0] sat_inc(input logic [STALL_W-1:0] cnt);
        return (cnt == STALL_MAX) ? cnt : cnt + 1'b1;
    endfunction

    assign wb_opcode = opc_mem[id_wb];
    assign wb_is_hlt = (wb_opcode == OP_HLT);

    ////////////////////////////////////////////////////////////////////////////
    // Stage field capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (v_fetch) begin
            pc_mem[id_fetch] <= fetch_pc;
            if (in_stall)
                stall_mem[id_fetch] <= sat_inc(stall_mem[id_fetch]);
            else
                stall_mem[id_fetch] <= '0;  // First cycle of this ID in fetch
        end
        if (v_decode) begin
            opc_mem[id_decode] <= decode_opcode;
            if (in_stall)
                stall_mem[id_decode] <= sat_inc(stall_mem[id_decode]);
        end
        if (v_exec)
            exec_mem[id_exec] <= exec_result;
        if (v_mem)
            addr_mem[id_mem] <= mem_addr;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Retire record, one cycle after write-back
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_push <= 1'b0;
        end else begin
            rec_push <= v_wb;
        end
    end

    always_ff @(posedge clk) begin
        if (v_wb) begin
            rec_id           <= id_wb;
            rec_pc           <= pc_mem[id_wb];
            rec_opcode       <= wb_opcode;
            rec_stall_cycles <= stall_mem[id_wb];
            rec_exec         <= wb_is_hlt ? '0 : exec_mem[id_wb];   // HLT has no later stages
            rec_mem          <= wb_is_hlt ? '0 : addr_mem[id_wb];
            rec_wb           <= wb_is_hlt ? '0 : wb_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/stage_tracker.sv
// Stage tracker that follows sequence IDs through the five pipeline stages and runs the halt FSM
`default_nettype none

module stage_tracker
    import cpu_isa_pkg::*;
    import trace_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,      // Freezes fetch and decode
    input  opcode_t         wb_opcode,  // Opcode stored for the write-back ID
    output logic            v_fetch,
    output logic            v_decode,
    output logic            v_exec,
    output logic            v_mem,
    output logic            v_wb,
    output logic [ID_W-1:0] id_fetch,
    output logic [ID_W-1:0] id_decode,
    output logic [ID_W-1:0] id_exec,
    output logic [ID_W-1:0] id_mem,
    output logic [ID_W-1:0] id_wb,
    output logic            in_stall,   // Fetch and decode slots count a stall cycle
    output logic            halted
);

    tracker_state_t       state, state_nxt;
    logic                 hlt_wb;       // HLT retiring this cycle
    logic                 frozen;       // Nothing moves once the halt is seen
    logic                 advance;      // Fetch and decode move on this edge
    logic [4:0]           v_vec;        // Stage valids, write-back at bit 0
    logic [4:0][ID_W-1:0] id_vec;       // Stage IDs, same order
    logic                 ids_ordered;

    assign hlt_wb   = v_wb && (wb_opcode == OP_HLT);
    assign frozen   = hlt_wb || (state == TRK_HALT_DRAIN) || (state == TRK_HALTED);
    assign advance  = !stall;
    assign in_stall = (state == TRK_STALL);
    assign halted   = (state == TRK_HALTED);

    ////////////////////////////////////////////////////////////////////////////
    // Tracker FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            TRK_RUN, TRK_STALL: begin
                if (hlt_wb) begin
                    state_nxt = TRK_HALT_DRAIN;     // Store pushes the HLT record next
                end else if (stall) begin
                    state_nxt = TRK_STALL;
                end else begin
                    state_nxt = TRK_RUN;
                end
            end
            TRK_HALT_DRAIN: state_nxt = TRK_HALTED;
            TRK_HALTED:     state_nxt = TRK_HALTED; // Only reset leaves
            default:        state_nxt = TRK_RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= TRK_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage valids and IDs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v_fetch  <= 1'b0;
            v_decode <= 1'b0;
            v_exec   <= 1'b0;
            v_mem    <= 1'b0;
            v_wb     <= 1'b0;
        end else if (frozen) begin
            v_fetch  <= 1'b0;   // Younger instructions are never traced
            v_decode <= 1'b0;
            v_exec   <= 1'b0;
            v_mem    <= 1'b0;
            v_wb     <= 1'b0;
        end else begin
            if (advance) begin
                v_fetch  <= 1'b1;   // CPU fetches every free cycle
                v_decode <= v_fetch;
            end
            v_exec <= advance ? v_decode : 1'b0;    // Bubble into execute on stall
            v_mem  <= v_exec;
            v_wb   <= v_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_fetch  <= '0;
            id_decode <= '0;
            id_exec   <= '0;
            id_mem    <= '0;
            id_wb     <= '0;
        end else begin
            if (advance) begin
                id_fetch  <= id_fetch + ID_W'(v_fetch);  // First fetch after reset keeps ID 0
                id_decode <= id_fetch;
                id_exec   <= id_decode;
            end
            id_mem <= id_exec;
            id_wb  <= id_mem;
        end
    end

    // Valid IDs must count up by one from write-back towards fetch
    assign v_vec  = {v_fetch, v_decode, v_exec, v_mem, v_wb};
    assign id_vec = {id_fetch, id_decode, id_exec, id_mem, id_wb};

    always_comb begin : id_order
        logic            seen;
        logic [ID_W-1:0] prev;
        seen        = 1'b0;
        prev        = '0;
        ids_ordered = 1'b1;
        for (int i = 0; i < 5; i++) begin
            if (v_vec[i]) begin
                if (seen && (id_vec[i] != ID_W'(prev + 1'b1)))
                    ids_ordered = 1'b0;
                seen = 1'b1;
                prev = id_vec[i];
            end
        end
    end

    a_no_wb_halted: assert property (@(posedge clk) disable iff (!rst_n)
        (state == TRK_HALTED) |-> !v_wb);

    a_ids_ordered: assert property (@(posedge clk) disable iff (!rst_n) ids_ordered);

endmodule

`default_nettype wire

//--- verilog/trace_pkg.sv
// Trace unit package with ID, record store, retire FIFO and credit sizing plus tracker states
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sequence IDs and per-ID record slots
    ////////////////////////////////////////////////////////////////////////////

    localparam int ID_W        = 3;             // Sequence ID width
    localparam int STORE_DEPTH = 1 << ID_W;     // One slot per ID value
    localparam int STALL_W     = 4;             // Stall counter width

    localparam logic [STALL_W-1:0] STALL_MAX = '1;  // Counter saturates here

    ////////////////////////////////////////////////////////////////////////////
    // Retire FIFO and credit stream
    ////////////////////////////////////////////////////////////////////////////

    localparam int QUEUE_DEPTH   = 4;                           // Records held under back-pressure
    localparam int QPTR_W        = $clog2(QUEUE_DEPTH);         // Read and write pointers
    localparam int QCNT_W        = $clog2(QUEUE_DEPTH + 1);     // Fill level 0..QUEUE_DEPTH
    localparam int TRACE_CREDITS = 4;                           // Consumer credits after reset
    localparam int CREDIT_W      = $clog2(TRACE_CREDITS + 1);   // Credit counter 0..TRACE_CREDITS

    // Packed record is id, pc, opcode, stall count, exec, mem, wb
    localparam int REC_W = ID_W + STALL_W + cpu_isa_pkg::OPC_W + 4 * cpu_isa_pkg::XLEN;

    // Tracker FSM
    typedef enum logic [1:0] {
        TRK_RUN        = 2'd0,  // Pipeline advancing
        TRK_STALL      = 2'd1,  // Fetch and decode held on the last edge
        TRK_HALT_DRAIN = 2'd2,  // HLT record leaving the store
        TRK_HALTED     = 2'd3   // Tracing stopped until reset
    } tracker_state_t;

endpackage

`default_nettype wire

//--- verilog/cpu_isa_pkg.sv
// CPU ISA package holding the datapath width and opcode classes seen by the trace unit
`default_nettype none

package cpu_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN  = 32;  // Data and PC width
    localparam int OPC_W = 4;   // Opcode class field

    ////////////////////////////////////////////////////////////////////////////
    // Opcode classes presented by decode
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [OPC_W-1:0] {
        OP_NOP    = 4'h0,   // No operation
        OP_ALU    = 4'h1,   // Register or immediate arithmetic
        OP_LOAD   = 4'h2,   // Memory read
        OP_STORE  = 4'h3,   // Memory write
        OP_BRANCH = 4'h4,   // Taken or not taken branch
        OP_HLT    = 4'hF    // Halt, last instruction traced
    } opcode_t;

endpackage

`default_nettype wire
